// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exits non-zero unless the run reports a pass
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_simd_unit -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_simd_unit 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1

// ==== source/delay_line.sv ====
// Fixed-depth register chain for any packed type T; all stages clear to zero at reset, DEPTH >= 1
`timescale 1ns/1ps

module delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  T     d_i,
    output T     q_o
);

    T stage_q [DEPTH];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= d_i;
            // Shift towards the output
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q_o = stage_q[DEPTH-1];

endmodule

// ==== source/lane_if.sv ====
// One lane's operands and result; no handshake, go and res_valid are single-cycle strobes
`timescale 1ns/1ps

interface lane_if
    import simd_pkg::*;
();

    logic       alu_go;      // Single-cycle operation issued
    logic       mul_go;      // VMUL issued
    vop_t       op;
    sew_t       sew;
    lane_word_t vs1_word;
    lane_word_t vs2_word;

    lane_word_t res_word;
    logic       res_valid;   // Pulses when res_word holds a finished result

    modport feed (
        output alu_go, mul_go, op, sew, vs1_word, vs2_word
    );

    modport lane (
        input  alu_go, mul_go, op, sew, vs1_word, vs2_word,
        output res_word, res_valid
    );

    modport drain (
        input res_word, res_valid
    );

endinterface

// ==== source/operand_splitter.sv ====
// Purely combinational issue decode; VMV_X_S starts no lane, and only one latency class is valid per issue
`timescale 1ns/1ps

module operand_splitter
    import simd_pkg::*;
(
    input  logic                 issue_valid_i,
    input  vop_t                 op_i,
    input  sew_t                 sew_i,
    input  src_t                 src_i,
    input  vreg_t                vs1_i,
    input  vreg_t                vs2_i,
    input  vreg_t                old_vd_i,
    input  lane_word_t           rs1_i,
    input  logic [4:0]           imm_i,
    input  logic                 use_mask_i,
    input  logic [MASK_W-1:0]    mask_i,
    input  logic [REG_IDX_W-1:0] vd_idx_i,
    input  logic [REG_IDX_W-1:0] rd_idx_i,
    lane_if.feed                 lanes_o [N_LANES],
    output ctrl_t                ctrl_fast_o,
    output ctrl_t                ctrl_mul_o
);

    lane_word_t scalar_src;
    vreg_t      bcast;
    vreg_t      op1;
    logic       is_mul;
    logic       is_alu;
    ctrl_t      rec;

    // Immediate goes to 64 bits first, truncating it later gives the SEW sign extension
    assign scalar_src = (src_i == SRC_VI) ? {{(ELEM_W-5){imm_i[4]}}, imm_i} : rs1_i;

    always_comb begin
        case (sew_i)
            SEW_8:   bcast = {(VLEN/8){scalar_src[7:0]}};
            SEW_16:  bcast = {(VLEN/16){scalar_src[15:0]}};
            SEW_32:  bcast = {(VLEN/32){scalar_src[31:0]}};
            default: bcast = {(VLEN/64){scalar_src}};
        endcase
    end

    assign op1    = (src_i == SRC_VV) ? vs1_i : bcast;
    assign is_mul = (op_i == VMUL);
    assign is_alu = !is_mul && (op_i != VMV_X_S);

    for (genvar g = 0; g < N_LANES; g++) begin : g_feed
        assign lanes_o[g].alu_go   = issue_valid_i && is_alu;
        assign lanes_o[g].mul_go   = issue_valid_i && is_mul;
        assign lanes_o[g].op       = op_i;
        assign lanes_o[g].sew      = sew_i;
        assign lanes_o[g].vs1_word = op1[g*ELEM_W +: ELEM_W];
        assign lanes_o[g].vs2_word = vs2_i[g*ELEM_W +: ELEM_W];
    end

    always_comb begin
        rec          = '{valid: 1'b0, op: op_i, sew: sew_i, use_mask: use_mask_i,
                         mask: mask_i, old_vd: old_vd_i, vd: vd_idx_i, rd: rd_idx_i,
                         vs2_e0: vs2_i[ELEM_W-1:0]};
        ctrl_fast_o       = rec;
        ctrl_fast_o.valid = issue_valid_i && !is_mul;    // ALU ops and VMV_X_S
        ctrl_mul_o        = rec;
        ctrl_mul_o.valid  = issue_valid_i && is_mul;
    end

endmodule

// ==== source/result_assembler.sv ====
// Combinational after its control delay lines; relies on the issue rule so fast and VMUL results never collide
`timescale 1ns/1ps

module result_assembler
    import simd_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    lane_if.drain                 lanes_i [N_LANES],
    input  ctrl_t                 ctrl_fast_i,
    input  ctrl_t                 ctrl_mul_i,
    output logic                  vec_valid_o,
    output logic [REG_IDX_W-1:0]  vec_vd_o,
    output vreg_t                 vec_result_o,
    output logic                  scal_valid_o,
    output logic [REG_IDX_W-1:0]  scal_rd_o,
    output lane_word_t            scal_result_o
);

    ctrl_t                fast_q;
    ctrl_t                mul_q;
    ctrl_t                sel;
    vreg_t                lane_cat;
    logic [N_LANES-1:0]   lane_done;

    // Control rides along with the matching lane pipeline
    delay_line #(
        .T     (ctrl_t),
        .DEPTH (1)
    ) u_fast_ctrl (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .d_i    (ctrl_fast_i),
        .q_o    (fast_q)
    );

    delay_line #(
        .T     (ctrl_t),
        .DEPTH (MUL_STAGES)
    ) u_mul_ctrl (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .d_i    (ctrl_mul_i),
        .q_o    (mul_q)
    );

    assign sel = mul_q.valid ? mul_q : fast_q;

    for (genvar g = 0; g < N_LANES; g++) begin : g_cat
        assign lane_cat[g*ELEM_W +: ELEM_W] = lanes_i[g].res_word;
        assign lane_done[g]                 = lanes_i[g].res_valid;
    end

    // Masking done bit by bit, element index is the bit position shifted by log2 of SEW
    always_comb begin
        int unsigned idx;
        for (int b = 0; b < VLEN; b++) begin
            idx = b >> (3 + int'(sel.sew));
            if (!sel.use_mask || sel.mask[idx]) begin
                vec_result_o[b] = lane_cat[b];
            end else begin
                vec_result_o[b] = sel.old_vd[b];    // Masked off, keep old value
            end
        end
    end

    assign vec_valid_o = sel.valid && (sel.op != VMV_X_S) && (&lane_done);
    assign vec_vd_o    = sel.vd;

    // VMV_X_S only travels on the fast path
    assign scal_valid_o = fast_q.valid && (fast_q.op == VMV_X_S);
    assign scal_rd_o    = fast_q.rd;

    always_comb begin
        case (fast_q.sew)
            SEW_8:   scal_result_o = {{56{fast_q.vs2_e0[7]}},  fast_q.vs2_e0[7:0]};
            SEW_16:  scal_result_o = {{48{fast_q.vs2_e0[15]}}, fast_q.vs2_e0[15:0]};
            SEW_32:  scal_result_o = {{32{fast_q.vs2_e0[31]}}, fast_q.vs2_e0[31:0]};
            default: scal_result_o = fast_q.vs2_e0;
        endcase
    end

endmodule

// ==== source/simd_lane.sv ====
// One 64-bit lane; ALU result one cycle after alu_go, VMUL two cycles after mul_go, the two never finish together
`timescale 1ns/1ps

module simd_lane
    import simd_pkg::*;
(
    input  logic clk_i,
    input  logic rstn_i,
    lane_if.lane lane_io
);

    lane_word_t             alu_res_d;
    lane_word_t             alu_res_q;
    logic                   alu_vld_q;
    lane_word_t             mul_res_q;
    lane_word_t             mul_res_dl;
    logic [MUL_STAGES-1:0]  mul_vld_q;

    // Add or subtract with the carry chain cut at every element boundary
    function automatic lane_word_t seg_addsub(lane_word_t a, lane_word_t b, logic sub,
                                              sew_t sew);
        lane_word_t bb;
        lane_word_t r;
        bb = sub ? ~b : b;    // Two's complement, carry-in supplied per element
        case (sew)
            SEW_8: for (int i = 0; i < 8; i++) begin
                r[8*i +: 8] = a[8*i +: 8] + bb[8*i +: 8] + {7'd0, sub};
            end
            SEW_16: for (int i = 0; i < 4; i++) begin
                r[16*i +: 16] = a[16*i +: 16] + bb[16*i +: 16] + {15'd0, sub};
            end
            SEW_32: for (int i = 0; i < 2; i++) begin
                r[32*i +: 32] = a[32*i +: 32] + bb[32*i +: 32] + {31'd0, sub};
            end
            default: r = a + bb + {63'd0, sub};
        endcase
        return r;
    endfunction

    // Element products, only the low SEW bits are kept
    function automatic lane_word_t seg_mul(lane_word_t a, lane_word_t b, sew_t sew);
        lane_word_t r;
        case (sew)
            SEW_8: for (int i = 0; i < 8; i++) begin
                r[8*i +: 8] = a[8*i +: 8] * b[8*i +: 8];
            end
            SEW_16: for (int i = 0; i < 4; i++) begin
                r[16*i +: 16] = a[16*i +: 16] * b[16*i +: 16];
            end
            SEW_32: for (int i = 0; i < 2; i++) begin
                r[32*i +: 32] = a[32*i +: 32] * b[32*i +: 32];
            end
            default: r = a * b;
        endcase
        return r;
    endfunction

    always_comb begin
        case (lane_io.op)
            VADD:    alu_res_d = seg_addsub(lane_io.vs2_word, lane_io.vs1_word, 1'b0, lane_io.sew);
            VSUB:    alu_res_d = seg_addsub(lane_io.vs2_word, lane_io.vs1_word, 1'b1, lane_io.sew);
            VAND:    alu_res_d = lane_io.vs2_word & lane_io.vs1_word;
            VOR:     alu_res_d = lane_io.vs2_word | lane_io.vs1_word;
            VXOR:    alu_res_d = lane_io.vs2_word ^ lane_io.vs1_word;
            default: alu_res_d = '0;
        endcase
    end

    // Valid bits
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            alu_vld_q <= 1'b0;
            mul_vld_q <= '0;
        end else begin
            alu_vld_q <= lane_io.alu_go;
            mul_vld_q <= {mul_vld_q[MUL_STAGES-2:0], lane_io.mul_go};
        end
    end

    always_ff @(posedge clk_i) begin
        if (lane_io.alu_go) alu_res_q <= alu_res_d;
        if (lane_io.mul_go) begin
            mul_res_q <= seg_mul(lane_io.vs2_word, lane_io.vs1_word, lane_io.sew);  // Stage 1
        end
    end

    delay_line #(
        .T     (lane_word_t),
        .DEPTH (MUL_STAGES - 1)
    ) u_mul_stage2 (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .d_i    (mul_res_q),
        .q_o    (mul_res_dl)
    );

    assign lane_io.res_valid = alu_vld_q | mul_vld_q[MUL_STAGES-1];
    assign lane_io.res_word  = alu_vld_q ? alu_res_q : mul_res_dl;

endmodule

// ==== source/simd_pkg.sv ====
// Shared widths and types for the vector unit; VLEN must stay a multiple of 64 and mask is one bit per element
package simd_pkg;

    localparam int VLEN       = 256;
    localparam int ELEM_W     = 64;            // Lane word width
    localparam int N_LANES    = VLEN / ELEM_W;
    localparam int MASK_W     = VLEN / 8;      // One bit per element at SEW 8
    localparam int MUL_STAGES = 2;             // VMUL latency in cycles
    localparam int REG_IDX_W  = 5;

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_t;

    typedef enum logic [2:0] {
        VADD,
        VSUB,      // vs2 minus vs1, as in RVV
        VAND,
        VOR,
        VXOR,
        VMUL,      // Low SEW bits of the product
        VMV_X_S
    } vop_t;

    typedef enum logic [1:0] {
        SRC_VV,
        SRC_VX,    // rs1 broadcast
        SRC_VI     // 5-bit signed immediate broadcast
    } src_t;

    typedef logic [ELEM_W-1:0] lane_word_t;
    typedef logic [VLEN-1:0]   vreg_t;

    // Everything the assembler needs once the lanes are done
    typedef struct packed {
        logic                 valid;
        vop_t                 op;
        sew_t                 sew;
        logic                 use_mask;
        logic [MASK_W-1:0]    mask;
        vreg_t                old_vd;
        logic [REG_IDX_W-1:0] vd;
        logic [REG_IDX_W-1:0] rd;
        lane_word_t           vs2_e0;    // Element 0 of vs2 for VMV_X_S
    } ctrl_t;

endpackage

// ==== source/simd_unit.sv ====
// Vector unit top; no back-pressure, results are one-cycle pulses and an issue right after VMUL must be VMUL or idle
`timescale 1ns/1ps

module simd_unit
    import simd_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    // Issue side
    input  logic                  issue_valid_i,
    input  vop_t                  op_i,
    input  sew_t                  sew_i,
    input  src_t                  src_i,
    input  vreg_t                 vs1_i,
    input  vreg_t                 vs2_i,
    input  vreg_t                 old_vd_i,
    input  lane_word_t            rs1_i,
    input  logic [4:0]            imm_i,
    input  logic                  use_mask_i,
    input  logic [MASK_W-1:0]     mask_i,
    input  logic [REG_IDX_W-1:0]  vd_idx_i,
    input  logic [REG_IDX_W-1:0]  rd_idx_i,
    // Write-back side
    output logic                  vec_valid_o,
    output logic [REG_IDX_W-1:0]  vec_vd_o,
    output vreg_t                 vec_result_o,
    output logic                  scal_valid_o,
    output logic [REG_IDX_W-1:0]  scal_rd_o,
    output lane_word_t            scal_result_o
);

    ctrl_t ctrl_fast;
    ctrl_t ctrl_mul;

    lane_if lane_bus [N_LANES] ();    // One bundle per lane

    operand_splitter u_splitter (
        .issue_valid_i (issue_valid_i),
        .op_i          (op_i),
        .sew_i         (sew_i),
        .src_i         (src_i),
        .vs1_i         (vs1_i),
        .vs2_i         (vs2_i),
        .old_vd_i      (old_vd_i),
        .rs1_i         (rs1_i),
        .imm_i         (imm_i),
        .use_mask_i    (use_mask_i),
        .mask_i        (mask_i),
        .vd_idx_i      (vd_idx_i),
        .rd_idx_i      (rd_idx_i),
        .lanes_o       (lane_bus),
        .ctrl_fast_o   (ctrl_fast),
        .ctrl_mul_o    (ctrl_mul)
    );

    for (genvar g = 0; g < N_LANES; g++) begin : g_lane
        simd_lane u_lane (
            .clk_i   (clk_i),
            .rstn_i  (rstn_i),
            .lane_io (lane_bus[g])
        );
    end

    result_assembler u_assembler (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .lanes_i       (lane_bus),
        .ctrl_fast_i   (ctrl_fast),
        .ctrl_mul_i    (ctrl_mul),
        .vec_valid_o   (vec_valid_o),
        .vec_vd_o      (vec_vd_o),
        .vec_result_o  (vec_result_o),
        .scal_valid_o  (scal_valid_o),
        .scal_rd_o     (scal_rd_o),
        .scal_result_o (scal_result_o)
    );

endmodule

// ==== testbench/simd_unit_props.sv ====
// Bound into simd_unit; assumes issue inputs are stable at the rising edge and hold no X after reset
`timescale 1ns/1ps

module simd_unit_props
    import simd_pkg::*;
(
    input logic                 clk_i,
    input logic                 rstn_i,
    input logic                 issue_valid_i,
    input vop_t                 op_i,
    input sew_t                 sew_i,
    input vreg_t                vs2_i,
    input logic [REG_IDX_W-1:0] vd_idx_i,
    input logic [REG_IDX_W-1:0] rd_idx_i,
    input logic                 vec_valid_o,
    input logic [REG_IDX_W-1:0] vec_vd_o,
    input logic                 scal_valid_o,
    input logic [REG_IDX_W-1:0] scal_rd_o,
    input lane_word_t           scal_result_o
);

    logic       fast_issue;
    logic       mul_issue;
    logic       mvx_issue;
    lane_word_t mvx_expect;
    int         sh;

    assign fast_issue = issue_valid_i && op_i != VMUL && op_i != VMV_X_S;
    assign mul_issue  = issue_valid_i && op_i == VMUL;
    assign mvx_issue  = issue_valid_i && op_i == VMV_X_S;

    // Element 0 of vs2, sign taken from bit SEW-1
    assign sh         = 64 - (8 << int'(sew_i));
    assign mvx_expect = lane_word_t'($signed(vs2_i[ELEM_W-1:0] << sh) >>> sh);

    a_issue_rule: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mul_issue |=> (!issue_valid_i || op_i == VMUL))
        else $error("Issue directly after VMUL was not a VMUL");

    a_fast_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
        fast_issue |=> (vec_valid_o && !scal_valid_o && vec_vd_o == $past(vd_idx_i)))
        else $error("Single-cycle op did not write back one cycle after issue");

    a_mul_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $past(mul_issue, 2) |-> (vec_valid_o && vec_vd_o == $past(vd_idx_i, 2)))
        else $error("VMUL did not write back two cycles after issue");

    a_mvx: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mvx_issue |=> (scal_valid_o && !vec_valid_o && scal_rd_o == $past(rd_idx_i)
                       && scal_result_o == $past(mvx_expect)))
        else $error("Scalar move result or timing is wrong");

    a_no_stray: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (vec_valid_o || scal_valid_o) |-> ($past(fast_issue || mvx_issue) || $past(mul_issue, 2)))
        else $error("Write-back valid with no matching issue");

endmodule

bind simd_unit simd_unit_props i_props (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .issue_valid_i (issue_valid_i),
    .op_i          (op_i),
    .sew_i         (sew_i),
    .vs2_i         (vs2_i),
    .vd_idx_i      (vd_idx_i),
    .rd_idx_i      (rd_idx_i),
    .vec_valid_o   (vec_valid_o),
    .vec_vd_o      (vec_vd_o),
    .scal_valid_o  (scal_valid_o),
    .scal_rd_o     (scal_rd_o),
    .scal_result_o (scal_result_o)
);

// ==== testbench/tb_clock.sv ====
// Free-running 8 ns clock; reset is held low for the first 5 rising edges and released 1 ns later
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rstn_o
);

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rstn_o = 1'b1;    // Released away from the edge
    end

endmodule

// ==== testbench/tb_simd_unit.sv ====
// Self-checking testbench; expected write-backs wait in a queue keyed to their completion cycle
`timescale 1ns/1ps

module tb_simd_unit
    import simd_pkg::*;
();

    localparam int N_RANDOM   = 40;
    localparam int WAIT_LIMIT = 20;    // Cycles any single wait may take

    typedef struct {
        int         due;               // Cycle count at which the result must show
        bit         is_vec;
        logic [4:0] idx;
        vreg_t      data;
    } exp_t;

    logic                 clk_i;
    logic                 rstn_i;
    logic                 issue_valid_i;
    vop_t                 op_i;
    sew_t                 sew_i;
    src_t                 src_i;
    vreg_t                vs1_i;
    vreg_t                vs2_i;
    vreg_t                old_vd_i;
    lane_word_t           rs1_i;
    logic [4:0]           imm_i;
    logic                 use_mask_i;
    logic [MASK_W-1:0]    mask_i;
    logic [REG_IDX_W-1:0] vd_idx_i;
    logic [REG_IDX_W-1:0] rd_idx_i;
    logic                 vec_valid_o;
    logic [REG_IDX_W-1:0] vec_vd_o;
    vreg_t                vec_result_o;
    logic                 scal_valid_o;
    logic [REG_IDX_W-1:0] scal_rd_o;
    lane_word_t           scal_result_o;

    exp_t   exp_q[$];
    int     cyc;
    int     errors;
    int     timeouts;
    int     n_checked;
    int     n_issued;
    int     waited;
    bit     last_mul;
    integer seed = 32'h4556;

    tb_clock i_clock (.clk_o(clk_i), .rstn_o(rstn_i));

    simd_unit i_simd_unit (.*);

    always @(posedge clk_i) cyc <= cyc + 1;

    function automatic lane_word_t elem_ones(sew_t sew);
        return (sew == SEW_64) ? '1 : ((64'd1 << (8 << int'(sew))) - 64'd1);
    endfunction

    // Low SEW bits of a scalar repeated over the whole vector
    function automatic vreg_t splat(lane_word_t s, sew_t sew);
        vreg_t v;
        v = '0;
        for (int i = 0; i < (VLEN >> (3 + int'(sew))); i++) begin
            v = v | ({{(VLEN-ELEM_W){1'b0}}, s & elem_ones(sew)} << (i * (8 << int'(sew))));
        end
        return v;
    endfunction

    function automatic vreg_t ref_vec(vop_t op, sew_t sew, vreg_t a2, vreg_t a1, logic um,
                                      logic [MASK_W-1:0] mk, vreg_t old);
        int         w;
        lane_word_t m;
        lane_word_t e2;
        lane_word_t e1;
        lane_word_t r;
        vreg_t      v;
        w = 8 << int'(sew);
        m = elem_ones(sew);
        v = '0;
        for (int i = 0; i < VLEN / w; i++) begin
            e2 = 64'(a2 >> (i * w)) & m;
            e1 = 64'(a1 >> (i * w)) & m;
            case (op)
                VADD:    r = e2 + e1;
                VSUB:    r = e2 - e1;
                VAND:    r = e2 & e1;
                VOR:     r = e2 | e1;
                VXOR:    r = e2 ^ e1;
                default: r = e2 * e1;    // VMUL, only low SEW bits survive the mask
            endcase
            if (um && !mk[i]) r = 64'(old >> (i * w));
            v = v | ({{(VLEN-ELEM_W){1'b0}}, r & m} << (i * w));
        end
        return v;
    endfunction

    function automatic lane_word_t sext_elem0(lane_word_t e0, sew_t sew);
        int sh;
        sh = 64 - (8 << int'(sew));
        return lane_word_t'($signed(e0 << sh) >>> sh);
    endfunction

    function automatic vreg_t rand_vec();
        vreg_t v;
        for (int i = 0; i < VLEN / 32; i++) begin
            v[32*i +: 32] = $random(seed);
        end
        return v;
    endfunction

    function automatic int rnd_below(int n);
        return int'(($random(seed) & 32'h7fff_ffff) % n);
    endfunction

    task automatic report_mismatch(string what, vreg_t got, vreg_t want);
        $display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
        errors++;
    endtask

    task automatic go_idle();
        @(posedge clk_i);
        #1;
        issue_valid_i = 1'b0;
        last_mul      = 1'b0;
    endtask

    // One issue strobe plus its expected write-back; an idle cycle goes in first after VMUL
    task automatic issue(vop_t op, sew_t sew, src_t src, vreg_t a1, vreg_t a2, lane_word_t sc,
                         logic [4:0] im, logic um, logic [MASK_W-1:0] mk);
        exp_t  e;
        vreg_t first;
        if (last_mul && op != VMUL) go_idle();
        @(posedge clk_i);
        #1;
        issue_valid_i = 1'b1;
        op_i          = op;
        sew_i         = sew;
        src_i         = src;
        vs1_i         = a1;
        vs2_i         = a2;
        old_vd_i      = ~a2;
        rs1_i         = sc;
        imm_i         = im;
        use_mask_i    = um;
        mask_i        = mk;
        vd_idx_i      = 5'(n_issued);
        rd_idx_i      = 5'(n_issued * 3);
        first    = (src == SRC_VV) ? a1 : splat((src == SRC_VI) ? {{59{im[4]}}, im} : sc, sew);
        e.due    = cyc + ((op == VMUL) ? 2 : 1);
        e.is_vec = (op != VMV_X_S);
        e.idx    = e.is_vec ? vd_idx_i : rd_idx_i;
        e.data   = e.is_vec ? ref_vec(op, sew, a2, first, um, mk, old_vd_i)
                            : {{(VLEN-ELEM_W){1'b0}}, sext_elem0(a2[ELEM_W-1:0], sew)};
        exp_q.push_back(e);
        last_mul = (op == VMUL);
        n_issued++;
    endtask

    task automatic drain();
        int w;
        go_idle();
        w = 0;
        while (exp_q.size() != 0 && w < WAIT_LIMIT) begin
            @(posedge clk_i);
            w++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d expected write-backs were never seen", exp_q.size());
            timeouts++;
            exp_q.delete();
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk_i) begin
        exp_t e;
        if (rstn_i && exp_q.size() != 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            n_checked++;
            assert (vec_valid_o == e.is_vec && scal_valid_o == !e.is_vec)
                else report_mismatch("valid pair", vreg_t'({vec_valid_o, scal_valid_o}),
                                     vreg_t'({e.is_vec, !e.is_vec}));
            if (e.is_vec) begin
                assert (vec_vd_o == e.idx)
                    else report_mismatch("vd index", vreg_t'(vec_vd_o), vreg_t'(e.idx));
                assert (vec_result_o == e.data)
                    else report_mismatch("vector result", vec_result_o, e.data);
            end else begin
                assert (scal_rd_o == e.idx)
                    else report_mismatch("rd index", vreg_t'(scal_rd_o), vreg_t'(e.idx));
                assert (scal_result_o == e.data[ELEM_W-1:0])
                    else report_mismatch("scalar result", vreg_t'(scal_result_o), e.data);
            end
        end else if (rstn_i) begin
            assert (!vec_valid_o && !scal_valid_o)    // Nothing due this cycle
                else report_mismatch("idle valid pair", vreg_t'({vec_valid_o, scal_valid_o}), '0);
        end
    end

    initial begin
        issue_valid_i = 1'b0;
        op_i          = VADD;
        sew_i         = SEW_8;
        src_i         = SRC_VV;
        vs1_i         = '0;
        vs2_i         = '0;
        old_vd_i      = '0;
        rs1_i         = '0;
        imm_i         = '0;
        use_mask_i    = 1'b0;
        mask_i        = '0;
        vd_idx_i      = '0;
        rd_idx_i      = '0;
        waited        = 0;
        while (!rstn_i && waited < WAIT_LIMIT) begin
            @(posedge clk_i);
            waited++;
        end
        if (!rstn_i) begin
            $display("Timeout: reset was never released");
            timeouts++;
        end
        repeat (3) @(posedge clk_i);    // Idle, both valids must stay low
        // All ones plus one wraps every element, so a carry across elements would show
        for (int s = 0; s < 4; s++) begin
            for (int o = 0; o <= int'(VXOR); o++) begin
                issue(vop_t'(o), sew_t'(s), SRC_VV, splat(64'h1, sew_t'(s)), '1, 64'd0, 5'd0,
                      1'b0, '0);
                issue(vop_t'(o), sew_t'(s), SRC_VV, rand_vec(), rand_vec(), 64'd0, 5'd0, 1'b0, '0);
            end
        end
        drain();
        for (int s = 0; s < 4; s++) begin
            issue(VMUL, sew_t'(s), SRC_VV, rand_vec(), rand_vec(), 64'd0, 5'd0, 1'b0, '0);
            issue(VMUL, sew_t'(s), SRC_VV, rand_vec(), rand_vec(), 64'd0, 5'd0, 1'b0, '0);
        end
        drain();
        // Scalar and immediate operands, then masking
        for (int s = 0; s < 4; s++) begin
            issue(VADD, sew_t'(s), SRC_VX, '0, rand_vec(), 64'h8123_4567_89ab_cdef, 5'd0, 1'b0, '0);
            issue(VSUB, sew_t'(s), SRC_VI, '0, rand_vec(), 64'd0, 5'h13, 1'b0, '0);
            issue(VXOR, sew_t'(s), SRC_VI, '0, '0, 64'd0, 5'h0b, 1'b0, '0);
            issue(VADD, sew_t'(s), SRC_VV, rand_vec(), rand_vec(), 64'd0, 5'd0, 1'b1, $random(seed));
            issue(VMUL, sew_t'(s), SRC_VX, '0, rand_vec(), 64'hfffd, 5'd0, 1'b1, $random(seed));
        end
        drain();
        for (int s = 0; s < 4; s++) begin
            issue(VMV_X_S, sew_t'(s), SRC_VV, '0, (rand_vec() << 64) | 256'h8765_4321_f0e1_d2c3,
                  64'd0, 5'd0, 1'b0, '0);
            issue(VMV_X_S, sew_t'(s), SRC_VV, '0, (rand_vec() << 64) | 256'h0123_4567_7f6e_5d4c,
                  64'd0, 5'd0, 1'b0, '0);
        end
        drain();
        for (int n = 0; n < N_RANDOM; n++) begin
            issue(vop_t'(rnd_below(7)), sew_t'(rnd_below(4)), src_t'(rnd_below(3)), rand_vec(),
                  rand_vec(), {$random(seed), $random(seed)}, 5'($random(seed)),
                  1'($random(seed)), $random(seed));
            if (rnd_below(4) == 0) go_idle();
        end
        drain();
        $display("Checked %0d write-backs: %0d errors, %0d timeouts", n_checked, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
source/simd_pkg.sv
source/lane_if.sv
source/delay_line.sv
source/operand_splitter.sv
source/simd_lane.sv
source/result_assembler.sv
source/simd_unit.sv
testbench/tb_clock.sv
testbench/simd_unit_props.sv
testbench/tb_simd_unit.sv
